// ==== cpu_core.f ====
+incdir+src
src/cpu_pkg.sv
src/control_unit.sv
src/reg_file.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_core.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run with Verilator, success only if the pass line is printed
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal -f cpu_core.f --top-module cpu_core_tb \
		-o sim_cpu_core \
	&& ./obj_dir/sim_cpu_core | grep -F -x "** PASS **" \
	|| { echo "Simulation did not pass"; exit 1; }

// ==== src/control_unit.sv ====
`include "cpu_consts.svh"

module control_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] imm,
	output logic               d_valid,
	output cpu_pkg::alu_fn_t   d_alu_fn,
	output logic [`REG_AW-1:0] d_rd,
	output logic [`REG_AW-1:0] d_rs,
	output logic [`DATA_W-1:0] d_imm,
	output logic               d_use_imm,
	output logic               d_reg_we,
	output logic               d_mem_rd,
	output logic               d_mem_wr,
	output logic               d_stack,
	output logic               d_push,
	output logic               d_io_in,
	output logic               d_io_out
);

	logic [8:0]       opcode;
	cpu_pkg::alu_fn_t alu_fn;
	logic             use_imm;
	logic             reg_we;
	logic             mem_rd;
	logic             mem_wr;
	logic             stack;
	logic             push;
	logic             io_in;
	logic             io_out;

	assign opcode = instr[15:7];

	always_comb begin
		// Defaults give a NOP
		alu_fn  = cpu_pkg::ALU_NOP;
		use_imm = 1'b0;
		reg_we  = 1'b0;
		mem_rd  = 1'b0;
		mem_wr  = 1'b0;
		stack   = 1'b0;
		push    = 1'b0;
		io_in   = 1'b0;
		io_out  = 1'b0;
		case (opcode)
			`OP_NOP:  alu_fn = cpu_pkg::ALU_NOP;
			`OP_SETC: alu_fn = cpu_pkg::ALU_SETC;
			`OP_CLRC: alu_fn = cpu_pkg::ALU_CLRC;
			`OP_NOT: begin
				alu_fn = cpu_pkg::ALU_NOT;
				reg_we = 1'b1;
			end
			`OP_INC: begin
				alu_fn = cpu_pkg::ALU_INC;
				reg_we = 1'b1;
			end
			`OP_DEC: begin
				alu_fn = cpu_pkg::ALU_DEC;
				reg_we = 1'b1;
			end
			`OP_OUT: begin
				alu_fn = cpu_pkg::ALU_PASS_A; // Rd to the port
				io_out = 1'b1;
			end
			`OP_IN: begin
				reg_we = 1'b1;
				io_in  = 1'b1;
			end
			`OP_MOV: begin
				alu_fn = cpu_pkg::ALU_PASS_B;
				reg_we = 1'b1;
			end
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR: begin
				// Low opcode bits line up with the ALU code order
				alu_fn = cpu_pkg::alu_fn_t'(4'd7 + 4'(opcode[2:0]));
				reg_we = 1'b1;
			end
			`OP_SHL_IMM: begin
				alu_fn  = cpu_pkg::ALU_SHL;
				use_imm = 1'b1;
				reg_we  = 1'b1;
			end
			`OP_SHR_IMM: begin
				alu_fn  = cpu_pkg::ALU_SHR;
				use_imm = 1'b1;
				reg_we  = 1'b1;
			end
			`OP_PUSH: begin
				alu_fn = cpu_pkg::ALU_PASS_A;
				mem_wr = 1'b1;
				stack  = 1'b1;
				push   = 1'b1;
			end
			`OP_POP: begin
				reg_we = 1'b1;
				mem_rd = 1'b1;
				stack  = 1'b1;
			end
			`OP_LDM: begin
				alu_fn  = cpu_pkg::ALU_PASS_B;
				use_imm = 1'b1; // Rd <= imm
				reg_we  = 1'b1;
			end
			`OP_LDD: begin
				alu_fn = cpu_pkg::ALU_PASS_B; // Address from Rs
				reg_we = 1'b1;
				mem_rd = 1'b1;
			end
			`OP_STD: begin
				alu_fn = cpu_pkg::ALU_PASS_B;
				mem_wr = 1'b1;
			end
			`OP_JZ, `OP_JN, `OP_JC, `OP_JMP, `OP_JMPI, `OP_CALL, `OP_RET, `OP_RTI: begin
				alu_fn = cpu_pkg::ALU_NOP; // No program counter
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_valid   <= 1'b0;
			d_alu_fn  <= cpu_pkg::ALU_NOP;
			d_use_imm <= 1'b0;
			d_reg_we  <= 1'b0;
			d_mem_rd  <= 1'b0;
			d_mem_wr  <= 1'b0;
			d_stack   <= 1'b0;
			d_push    <= 1'b0;
			d_io_in   <= 1'b0;
			d_io_out  <= 1'b0;
		end else begin
			d_valid <= in_valid;
			if (in_valid) begin
				d_alu_fn  <= alu_fn;
				d_use_imm <= use_imm;
				d_reg_we  <= reg_we;
				d_mem_rd  <= mem_rd;
				d_mem_wr  <= mem_wr;
				d_stack   <= stack;
				d_push    <= push;
				d_io_in   <= io_in;
				d_io_out  <= io_out;
			end
		end
	end

	// Operand fields
	always_ff @(posedge clk) begin
		if (in_valid) begin
			d_rd  <= instr[6:4];
			d_rs  <= instr[3:1];
			d_imm <= imm;
		end
	end

endmodule

// ==== src/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath sizing
`define DATA_W   16
`define REG_AW   3
`define MEM_AW   8   // 256 data words
`define SP_RESET 255 // Stack grows down from the top word

// Opcodes, instr[15:7]
`define OP_NOP     9'b000_000000
`define OP_SETC    9'b000_000001
`define OP_CLRC    9'b000_000010

// One operand group
`define OP_NOT     9'b001_000000
`define OP_INC     9'b001_000001
`define OP_DEC     9'b001_000010
`define OP_OUT     9'b001_000011
`define OP_IN      9'b001_000100

// Two operand group
`define OP_MOV     9'b010_000000
`define OP_ADD     9'b010_000001
`define OP_SUB     9'b010_000010
`define OP_AND     9'b010_000011
`define OP_OR      9'b010_000100
`define OP_SHL     9'b010_000101
`define OP_SHR     9'b010_000110
`define OP_SHL_IMM 9'b010_000111
`define OP_SHR_IMM 9'b010_001000

// Memory group
`define OP_PUSH    9'b011_000000
`define OP_POP     9'b011_000001
`define OP_LDM     9'b011_000010
`define OP_LDD     9'b011_000011
`define OP_STD     9'b011_000100

// Branch group, no fetch unit here so these retire as NOP
`define OP_JZ      9'b100_000000
`define OP_JN      9'b100_000001
`define OP_JC      9'b100_000010
`define OP_JMP     9'b100_000100
`define OP_JMPI    9'b100_000101
`define OP_CALL    9'b100_000110
`define OP_RET     9'b100_001000
`define OP_RTI     9'b100_001010

`endif

// ==== src/cpu_core.sv ====
`include "cpu_consts.svh"

module cpu_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] imm,
	input  logic [`DATA_W-1:0] in_port,
	output logic               retire_valid,
	output logic               retire_we,
	output logic [`REG_AW-1:0] retire_dst,
	output logic [`DATA_W-1:0] retire_data,
	output logic [2:0]         retire_flags,
	output logic               out_valid,
	output logic [`DATA_W-1:0] out_data
);

	// Decode to execute
	logic               d_valid;
	cpu_pkg::alu_fn_t   d_alu_fn;
	logic [`REG_AW-1:0] d_rd;
	logic [`REG_AW-1:0] d_rs;
	logic [`DATA_W-1:0] d_imm;
	logic               d_use_imm;
	logic               d_reg_we;
	logic               d_mem_rd;
	logic               d_mem_wr;
	logic               d_stack;
	logic               d_push;
	logic               d_io_in;
	logic               d_io_out;

	// Execute to memory
	logic               x_valid;
	logic [`REG_AW-1:0] x_rd;
	logic               x_reg_we;
	logic               x_mem_rd;
	logic               x_mem_wr;
	logic               x_stack;
	logic               x_push;
	logic               x_io_in;
	logic               x_io_out;
	logic [`DATA_W-1:0] x_result;
	logic [`DATA_W-1:0] x_store_data;
	logic [2:0]         x_flags;

	// Register file read side and memory-stage forward
	logic [`REG_AW-1:0] rf_raddr_a;
	logic [`REG_AW-1:0] rf_raddr_b;
	logic [`DATA_W-1:0] rf_a;
	logic [`DATA_W-1:0] rf_b;
	logic               m_valid;
	logic [`REG_AW-1:0] m_dst;
	logic [`DATA_W-1:0] m_data;

	control_unit u_decode (
		.clk, .rst_n, .in_valid, .instr, .imm,
		.d_valid, .d_alu_fn, .d_rd, .d_rs, .d_imm, .d_use_imm, .d_reg_we,
		.d_mem_rd, .d_mem_wr, .d_stack, .d_push, .d_io_in, .d_io_out
	);

	execute_stage u_execute (
		.clk, .rst_n,
		.d_valid, .d_alu_fn, .d_rd, .d_rs, .d_imm, .d_use_imm, .d_reg_we,
		.d_mem_rd, .d_mem_wr, .d_stack, .d_push, .d_io_in, .d_io_out,
		.rf_a, .rf_b,
		.fwd_m_valid (m_valid),
		.fwd_m_dst   (m_dst),
		.fwd_m_data  (m_data),
		.fwd_w_valid (retire_we),
		.fwd_w_dst   (retire_dst),
		.fwd_w_data  (retire_data),
		.rf_raddr_a, .rf_raddr_b,
		.x_valid, .x_rd, .x_reg_we, .x_mem_rd, .x_mem_wr, .x_stack, .x_push,
		.x_io_in, .x_io_out, .x_result, .x_store_data, .x_flags
	);

	memory_stage u_memory (
		.clk, .rst_n,
		.x_valid, .x_rd, .x_reg_we, .x_mem_rd, .x_mem_wr, .x_stack, .x_push,
		.x_io_in, .x_io_out, .x_result, .x_store_data, .x_flags, .in_port,
		.m_valid, .m_dst, .m_data,
		.retire_valid, .retire_we, .retire_dst, .retire_data, .retire_flags,
		.out_valid, .out_data
	);

	// Retire port doubles as the write port
	reg_file u_regs (
		.clk, .rst_n,
		.we      (retire_we),
		.waddr   (retire_dst),
		.wdata   (retire_data),
		.raddr_a (rf_raddr_a),
		.raddr_b (rf_raddr_b),
		.rdata_a (rf_a),
		.rdata_b (rf_b)
	);

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	// ALU function select, passed from decode to execute
	typedef enum logic [3:0] {
		ALU_NOP    = 4'b0000,
		ALU_SETC   = 4'b0001, // C <= 1
		ALU_CLRC   = 4'b0010, // C <= 0
		ALU_PASS_A = 4'b0011, // Rd value through
		ALU_PASS_B = 4'b0100, // Rs or immediate through
		ALU_NOT    = 4'b0101,
		ALU_INC    = 4'b0110,
		ALU_DEC    = 4'b0111,
		ALU_ADD    = 4'b1000,
		ALU_SUB    = 4'b1001,
		ALU_AND    = 4'b1010,
		ALU_OR     = 4'b1011,
		ALU_SHL    = 4'b1100, // Shift count from B[3:0]
		ALU_SHR    = 4'b1101
	} alu_fn_t;

	// Encodings 4'b1110 and 4'b1111 are unused

endpackage

// ==== src/execute_stage.sv ====
`include "cpu_consts.svh"

module execute_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               d_valid,
	input  cpu_pkg::alu_fn_t   d_alu_fn,
	input  logic [`REG_AW-1:0] d_rd,
	input  logic [`REG_AW-1:0] d_rs,
	input  logic [`DATA_W-1:0] d_imm,
	input  logic               d_use_imm,
	input  logic               d_reg_we,
	input  logic               d_mem_rd,
	input  logic               d_mem_wr,
	input  logic               d_stack,
	input  logic               d_push,
	input  logic               d_io_in,
	input  logic               d_io_out,
	input  logic [`DATA_W-1:0] rf_a,
	input  logic [`DATA_W-1:0] rf_b,
	input  logic               fwd_m_valid,
	input  logic [`REG_AW-1:0] fwd_m_dst,
	input  logic [`DATA_W-1:0] fwd_m_data,
	input  logic               fwd_w_valid,
	input  logic [`REG_AW-1:0] fwd_w_dst,
	input  logic [`DATA_W-1:0] fwd_w_data,
	output logic [`REG_AW-1:0] rf_raddr_a,
	output logic [`REG_AW-1:0] rf_raddr_b,
	output logic               x_valid,
	output logic [`REG_AW-1:0] x_rd,
	output logic               x_reg_we,
	output logic               x_mem_rd,
	output logic               x_mem_wr,
	output logic               x_stack,
	output logic               x_push,
	output logic               x_io_in,
	output logic               x_io_out,
	output logic [`DATA_W-1:0] x_result,
	output logic [`DATA_W-1:0] x_store_data,
	output logic [2:0]         x_flags
);

	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] rs_val;
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] res;
	logic [`DATA_W:0]   wide;   // Result with carry or shifted-out bit
	logic [3:0]         shamt;
	logic               zn_upd;
	logic               c_next;
	logic               flag_z;
	logic               flag_n;
	logic               flag_c;

	// Newest producer wins: memory stage, then retire, then register file
	function automatic logic [`DATA_W-1:0] fwd(
		input logic [`REG_AW-1:0] idx,
		input logic [`DATA_W-1:0] rf_val,
		input logic               m_vld,
		input logic [`REG_AW-1:0] m_dst,
		input logic [`DATA_W-1:0] m_data,
		input logic               w_vld,
		input logic [`REG_AW-1:0] w_dst,
		input logic [`DATA_W-1:0] w_data
	);
		if (m_vld && m_dst == idx)
			return m_data;
		if (w_vld && w_dst == idx)
			return w_data;
		return rf_val;
	endfunction

	assign rf_raddr_a = d_rd;
	assign rf_raddr_b = d_rs;

	assign op_a = fwd(d_rd, rf_a, fwd_m_valid, fwd_m_dst, fwd_m_data,
		fwd_w_valid, fwd_w_dst, fwd_w_data);
	assign rs_val = fwd(d_rs, rf_b, fwd_m_valid, fwd_m_dst, fwd_m_data,
		fwd_w_valid, fwd_w_dst, fwd_w_data);
	assign op_b  = d_use_imm ? d_imm : rs_val;
	assign shamt = op_b[3:0];

	always_comb begin
		res    = op_a;
		wide   = '0;
		zn_upd = 1'b0;
		c_next = flag_c;
		case (d_alu_fn)
			cpu_pkg::ALU_SETC:   c_next = 1'b1;
			cpu_pkg::ALU_CLRC:   c_next = 1'b0;
			cpu_pkg::ALU_PASS_A: res = op_a;
			cpu_pkg::ALU_PASS_B: res = op_b;
			cpu_pkg::ALU_NOT: begin
				res    = ~op_a;
				zn_upd = 1'b1;
			end
			cpu_pkg::ALU_INC, cpu_pkg::ALU_DEC, cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: begin
				case (d_alu_fn)
					cpu_pkg::ALU_INC: wide = {1'b0, op_a} + 17'd1;
					cpu_pkg::ALU_DEC: wide = {1'b0, op_a} - 17'd1; // Bit 16 is the borrow
					cpu_pkg::ALU_ADD: wide = {1'b0, op_a} + {1'b0, op_b};
					default:          wide = {1'b0, op_a} - {1'b0, op_b};
				endcase
				res    = wide[`DATA_W-1:0];
				c_next = wide[`DATA_W];
				zn_upd = 1'b1;
			end
			cpu_pkg::ALU_AND: begin
				res    = op_a & op_b;
				zn_upd = 1'b1;
			end
			cpu_pkg::ALU_OR: begin
				res    = op_a | op_b;
				zn_upd = 1'b1;
			end
			cpu_pkg::ALU_SHL: begin
				wide   = {1'b0, op_a} << shamt;
				res    = wide[`DATA_W-1:0];
				zn_upd = 1'b1;
				if (shamt != 4'd0)
					c_next = wide[`DATA_W]; // Last bit out of the top
			end
			cpu_pkg::ALU_SHR: begin
				wide   = {op_a, 1'b0} >> shamt;
				res    = wide[`DATA_W:1];
				zn_upd = 1'b1;
				if (shamt != 4'd0)
					c_next = wide[0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			x_valid  <= 1'b0;
			x_reg_we <= 1'b0;
			x_mem_rd <= 1'b0;
			x_mem_wr <= 1'b0;
			x_stack  <= 1'b0;
			x_push   <= 1'b0;
			x_io_in  <= 1'b0;
			x_io_out <= 1'b0;
			flag_z   <= 1'b0;
			flag_n   <= 1'b0;
			flag_c   <= 1'b0;
		end else begin
			// Controls are qualified here so later stages need no valid gating
			x_valid  <= d_valid;
			x_reg_we <= d_valid & d_reg_we;
			x_mem_rd <= d_valid & d_mem_rd;
			x_mem_wr <= d_valid & d_mem_wr;
			x_stack  <= d_valid & d_stack;
			x_push   <= d_valid & d_push;
			x_io_in  <= d_valid & d_io_in;
			x_io_out <= d_valid & d_io_out;
			if (d_valid) begin
				flag_c <= c_next;
				if (zn_upd) begin
					flag_z <= (res == '0);
					flag_n <= res[`DATA_W-1];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (d_valid) begin
			x_rd         <= d_rd;
			x_result     <= res;
			x_store_data <= op_a; // Rd for STD, PUSH and OUT
		end
	end

	assign x_flags = {flag_z, flag_n, flag_c};

endmodule

// ==== src/memory_stage.sv ====
`include "cpu_consts.svh"

module memory_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               x_valid,
	input  logic [`REG_AW-1:0] x_rd,
	input  logic               x_reg_we,
	input  logic               x_mem_rd,
	input  logic               x_mem_wr,
	input  logic               x_stack,
	input  logic               x_push,
	input  logic               x_io_in,
	input  logic               x_io_out,
	input  logic [`DATA_W-1:0] x_result,
	input  logic [`DATA_W-1:0] x_store_data,
	input  logic [2:0]         x_flags,
	input  logic [`DATA_W-1:0] in_port,
	output logic               m_valid,
	output logic [`REG_AW-1:0] m_dst,
	output logic [`DATA_W-1:0] m_data,
	output logic               retire_valid,
	output logic               retire_we,
	output logic [`REG_AW-1:0] retire_dst,
	output logic [`DATA_W-1:0] retire_data,
	output logic [2:0]         retire_flags,
	output logic               out_valid,
	output logic [`DATA_W-1:0] out_data
);

	localparam int MEM_DEPTH = 1 << `MEM_AW;

	logic [`DATA_W-1:0] mem [0:MEM_DEPTH-1];
	logic [`MEM_AW-1:0] sp;
	logic [`MEM_AW-1:0] addr;

	// Push writes at SP, pop reads at SP+1
	assign addr = x_stack ? (x_push ? sp : sp + 1'b1) : x_result[`MEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (x_mem_wr) begin
			mem[addr] <= x_store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sp <= `MEM_AW'(`SP_RESET);
		else if (x_stack)
			sp <= x_push ? sp - 1'b1 : sp + 1'b1;
	end

	// Load data is ready this cycle so it forwards like any result
	always_comb begin
		if (x_mem_rd)
			m_data = mem[addr];
		else if (x_io_in)
			m_data = in_port;
		else
			m_data = x_result;
	end

	assign m_valid = x_reg_we;
	assign m_dst   = x_rd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			retire_we    <= 1'b0;
			retire_flags <= 3'b000;
			out_valid    <= 1'b0;
		end else begin
			retire_valid <= x_valid;
			retire_we    <= x_reg_we;
			retire_flags <= x_flags;
			out_valid    <= x_io_out; // Same cycle as the OUT retires
		end
	end

	always_ff @(posedge clk) begin
		retire_dst  <= x_rd;
		retire_data <= m_data;
		if (x_io_out)
			out_data <= x_store_data;
	end

endmodule

// ==== src/reg_file.sv ====
`include "cpu_consts.svh"

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               we,
	input  logic [`REG_AW-1:0] waddr,
	input  logic [`DATA_W-1:0] wdata,
	input  logic [`REG_AW-1:0] raddr_a,
	input  logic [`REG_AW-1:0] raddr_b,
	output logic [`DATA_W-1:0] rdata_a,
	output logic [`DATA_W-1:0] rdata_b
);

	logic [`DATA_W-1:0] regs [0:(1 << `REG_AW)-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << `REG_AW); i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// No bypass, the execute stage forwards
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

endmodule

// ==== tests/cpu_core_tb.sv ====
`include "cpu_consts.svh"

module cpu_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int N_INSTR     = 400;
	localparam int STACK_MAX   = 16; // Stack stays in words 240..255
	// Valid on about 3/4 of cycles so twice the count plus drain and reset is ample
	localparam int WATCHDOG_CYCLES = 2 * N_INSTR + 20 + 2;

	typedef struct packed {
		logic [31:0]        seq;
		logic [31:0]        due;  // Cycle in which retire_valid must show
		logic [8:0]         opc;
		logic               we;
		logic [`REG_AW-1:0] dst;
		logic [`DATA_W-1:0] data;
		logic [2:0]         flags; // Z, N, C
		logic               is_out;
		logic [`DATA_W-1:0] out_val;
	} exp_rec_t;

	logic               clk;
	logic               rst_n;
	logic               in_valid;
	logic [`DATA_W-1:0] instr;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] in_port;
	logic               retire_valid;
	logic               retire_we;
	logic [`REG_AW-1:0] retire_dst;
	logic [`DATA_W-1:0] retire_data;
	logic [2:0]         retire_flags;
	logic               out_valid;
	logic [`DATA_W-1:0] out_data;

	logic [31:0]        lfsr_state;
	int                 cycle;
	exp_rec_t           exp_q[$];
	logic [8:0]         op_list [32];

	// Architectural state
	logic [`DATA_W-1:0] m_regs [8];
	logic [`DATA_W-1:0] m_mem [256];
	logic [7:0]         m_sp;
	logic               m_z;
	logic               m_n;
	logic               m_c;
	int                 m_depth;

	cpu_core i_dut (
		.clk, .rst_n, .in_valid, .instr, .imm, .in_port,
		.retire_valid, .retire_we, .retire_dst, .retire_data, .retire_flags,
		.out_valid, .out_data
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Galois LFSR on x^32 + x^31 + x^29 + x + 1
	function automatic logic step_lfsr();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'hD000_0001;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], step_lfsr()};
		return v;
	endfunction

	task automatic abort_run(input string what);
		$display("ERROR: %s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// Applies one instruction to the architectural state
	task automatic model_step(input logic [15:0] ins, input logic [15:0] immv,
		inout exp_rec_t e);
		logic [8:0]  opc;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		logic [3:0]  sh;
		logic        wr;
		logic        zn;
		int          i;
		opc = ins[15:7];
		rd  = ins[6:4];
		rs  = ins[3:1];
		a   = m_regs[rd];
		b   = m_regs[rs];
		r   = '0;
		wr  = 1'b0;
		zn  = 1'b0;
		e.opc     = opc;
		e.dst     = rd;
		e.is_out  = 1'b0;
		e.out_val = '0;
		case (opc)
			`OP_SETC: m_c = 1'b1;
			`OP_CLRC: m_c = 1'b0;
			`OP_NOT: begin
				r  = ~a;
				wr = 1'b1;
				zn = 1'b1;
			end
			`OP_INC: begin
				m_c = (a == 16'hffff); // Carry out of all ones
				r   = a + 16'd1;
				wr  = 1'b1;
				zn  = 1'b1;
			end
			`OP_DEC: begin
				m_c = (a == 16'd0); // Borrow out of zero
				r   = a - 16'd1;
				wr  = 1'b1;
				zn  = 1'b1;
			end
			`OP_ADD: begin
				r   = a + b;
				m_c = (r < a); // Sum wrapped past the top
				wr  = 1'b1;
				zn  = 1'b1;
			end
			`OP_SUB: begin
				m_c = (a < b);
				r   = a - b;
				wr  = 1'b1;
				zn  = 1'b1;
			end
			`OP_AND, `OP_OR: begin
				r  = (opc == `OP_AND) ? (a & b) : (a | b);
				wr = 1'b1;
				zn = 1'b1;
			end
			`OP_SHL, `OP_SHL_IMM, `OP_SHR, `OP_SHR_IMM: begin
				sh = (opc == `OP_SHL_IMM || opc == `OP_SHR_IMM) ? immv[3:0] : b[3:0];
				r  = a;
				for (i = 0; i < int'(sh); i++) begin // C ends on the last bit out
					if (opc == `OP_SHL || opc == `OP_SHL_IMM) begin
						m_c = r[15];
						r   = r << 1;
					end else begin
						m_c = r[0];
						r   = r >> 1;
					end
				end
				wr = 1'b1;
				zn = 1'b1;
			end
			`OP_MOV: begin
				r  = b;
				wr = 1'b1;
			end
			`OP_OUT: begin
				e.is_out  = 1'b1;
				e.out_val = a;
			end
			`OP_IN: begin
				r  = in_port;
				wr = 1'b1;
			end
			`OP_PUSH: begin
				m_mem[m_sp] = a;
				m_sp    = m_sp - 8'd1;
				m_depth = m_depth + 1;
			end
			`OP_POP: begin
				m_sp    = m_sp + 8'd1;
				r       = m_mem[m_sp];
				wr      = 1'b1;
				m_depth = m_depth - 1;
			end
			`OP_LDM: begin
				r  = immv;
				wr = 1'b1;
			end
			`OP_LDD: begin
				r  = m_mem[b[7:0]];
				wr = 1'b1;
			end
			`OP_STD: m_mem[b[7:0]] = a;
			default: ; // Branches and unknown codes
		endcase
		if (zn) begin
			m_z = (r == 16'd0);
			m_n = r[15];
		end
		if (wr)
			m_regs[rd] = r;
		e.we    = wr;
		e.data  = r;
		e.flags = {m_z, m_n, m_c};
	endtask

	task automatic check_outputs();
		exp_rec_t e;
		string    tag;
		if (retire_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("retire_valid rose with no instruction in flight");
			end else begin
				e   = exp_q.pop_front();
				tag = $sformatf("instr %0d (op 9'h%03h)", e.seq, e.opc);
				check_value({tag, " retire cycle"}, e.due, 32'(cycle));
				check_value({tag, " retire_we"}, 32'(e.we), 32'(retire_we));
				if (e.we) begin
					check_value({tag, " retire_dst"}, 32'(e.dst), 32'(retire_dst));
					check_value({tag, " retire_data"}, 32'(e.data), 32'(retire_data));
				end
				check_value({tag, " retire_flags"}, 32'(e.flags), 32'(retire_flags));
				check_value({tag, " out_valid"}, 32'(e.is_out), 32'(out_valid));
				if (e.is_out)
					check_value({tag, " out_data"}, 32'(e.out_val), 32'(out_data));
			end
		end else if (retire_valid !== 1'b0) begin
			abort_run("retire_valid is unknown");
		end else if (exp_q.size() != 0 && exp_q[0].due <= 32'(cycle)) begin
			abort_run("an accepted instruction did not retire on time");
		end else begin
			check_value("idle out_valid", 32'd0, 32'(out_valid));
		end
	endtask

	initial begin
		exp_rec_t    e;
		logic [8:0]  opc;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [15:0] immv;
		int          accepted;
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		instr      = '0;
		imm        = '0;
		lfsr_state = 32'h6405_bbed;
		in_port    = 16'(rand_bits(16)); // Held for the whole run
		op_list = '{`OP_NOP, `OP_SETC, `OP_CLRC, `OP_NOT, `OP_INC, `OP_DEC, `OP_OUT,
			`OP_IN, `OP_MOV, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SHL, `OP_SHR,
			`OP_SHL_IMM, `OP_SHR_IMM, `OP_PUSH, `OP_POP, `OP_LDM, `OP_LDD, `OP_STD,
			`OP_JZ, `OP_JN, `OP_JC, `OP_JMP, `OP_JMPI, `OP_CALL, `OP_RET, `OP_RTI,
			9'h1ff, 9'b001_111111};
		for (int i = 0; i < 8; i++)
			m_regs[i] = '0;
		for (int i = 0; i < 256; i++)
			m_mem[i] = '0;
		m_sp     = 8'(`SP_RESET);
		m_z      = 1'b0;
		m_n      = 1'b0;
		m_c      = 1'b0;
		m_depth  = 0;
		cycle    = 0;
		accepted = 0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY rst_n = 1'b1;
		while (accepted < N_INSTR || exp_q.size() != 0) begin
			@(posedge clk);
			cycle++;
			#DRIVE_DELAY;
			check_outputs();
			if (accepted < N_INSTR && rand_bits(2) != 32'd0) begin
				opc  = op_list[rand_bits(5)];
				rd   = 3'(rand_bits(3));
				rs   = 3'(rand_bits(3));
				immv = rand_bits(1) ? 16'(rand_bits(4)) : 16'(rand_bits(16));
				// Keep the stack balanced and out of reach of STD
				if (opc == `OP_PUSH && m_depth >= STACK_MAX)
					opc = `OP_POP;
				else if (opc == `OP_POP && m_depth == 0)
					opc = `OP_PUSH;
				if (opc == `OP_STD && m_regs[rs][7:0] >= 8'hf0)
					opc = `OP_LDD;
				instr    = {opc, rd, rs, 1'(rand_bits(1))};
				imm      = immv;
				in_valid = 1'b1;
				e.seq    = 32'(accepted);
				e.due    = 32'(cycle + 3);
				model_step(instr, immv, e);
				exp_q.push_back(e);
				accepted++;
			end else begin
				in_valid = 1'b0;
			end
		end
		$display("** PASS **");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: timeout, retirement stalled");
		$display("** FAIL **");
		$fatal(1);
	end

endmodule
